/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = lagWindowTb
FILELIST = project.f
BUILDDIR = obj_dir
LOG      = sim.log
PASSMSG  = TEST PASSED

.PHONY: simulate clean

# Build, run, then decide on the log contents
simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASSMSG)" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

/* design/autocorrBuffer.sv */
`timescale 1ns/1ps
`default_nettype none

module autocorrBuffer
	import fixPkg::*, streamPkg::*;
(
	input wire logic clk,
	input wire logic rstN,
	input wire logic inValid,
	input wire word32 inData,
	output logic bufEmpty,
	input wire logic pop,
	output word32 popData,
	output logic inCredit
);

	// Storage, payload only
	word32 mem [bufDepth];

	bufPtr wrPtr;
	bufPtr rdPtr;

	// Words held, 0 to bufDepth
	logic [$clog2(bufDepth + 1) - 1:0] fill;

	//////////////////////////////////////////////////
	// Write side
	//////////////////////////////////////////////////

	// Credits bound the fill, so every valid word fits
	always_ff @(posedge clk)
	begin
		if (inValid)
			mem[wrPtr] <= inData;
	end

	// Pointers wrap at 16 by their width
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
		end
		else
		begin
			if (inValid)
				wrPtr <= wrPtr + bufPtr'(1);
			if (pop)
				rdPtr <= rdPtr + bufPtr'(1);
		end
	end

	// Fill count, both ends in one cycle cancel
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			fill <= '0;
		else if (inValid && !pop)
			fill <= fill + 1'b1;
		else if (pop && !inValid)
			fill <= fill - 1'b1;
	end

	//////////////////////////////////////////////////
	// Read side
	//////////////////////////////////////////////////

	// Head word shown combinationally
	assign popData = mem[rdPtr];
	assign bufEmpty = (fill == '0);

	// One credit back to the source per pop, a cycle later
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			inCredit <= 1'b0;
		else
			inCredit <= pop;
	end

endmodule

`default_nettype wire

/* design/dpfMultiplier.sv */
`timescale 1ns/1ps
`default_nettype none

module dpfMultiplier
	import fixPkg::*, streamPkg::*;
(
	input wire logic clk,
	input wire logic rstN,
	mpyIf.result res,
	mpyIf.issueIn iss,
	output logic outValid,
	output word32 outData
);

	// Signed add clamped to the 32-bit range
	function automatic word32 satAdd(input word32 a, input word32 b);
		logic signed [32:0] sum;
		sum = {a[31], a} + {b[31], b};
		if (sum[32] != sum[31])
			satAdd = sum[32] ? minWord32 : maxWord32;
		else
			satAdd = sum[31:0];
	endfunction

	// Operand split and table lookup
	word16 rHi;
	word16 rLo;
	word16 lagHi;
	word16 lagLo;
	logic [3:0] lagIdx;

	// Full 32-bit products
	word32 hiProd;
	word32 crossHiLo;
	word32 crossLoHi;

	// Stage 1 registers
	logic s1Valid;
	logic s1Bypass;
	word32 s1R;
	word32 s1Prod;
	word16 s1M1;
	word16 s1M2;

	// Stage 2 sum
	word32 sum1;
	word32 sum2;

	//////////////////////////////////////////////////
	// Stage 1
	//////////////////////////////////////////////////

	// DPF split, lo keeps 15 bits
	assign rHi = iss.issueR[31:16];
	assign rLo = word16'({1'b0, iss.issueR[15:1]});

	// Table starts at k = 1
	assign lagIdx = (iss.issueK == '0) ? 4'd0 : iss.issueK - 1'b1;
	assign lagHi = lagHiTable[lagIdx];
	assign lagLo = lagLoTable[lagIdx];

	assign hiProd = rHi * lagHi;
	assign crossHiLo = rHi * lagLo;
	assign crossLoHi = rLo * lagHi;

	// Control bits reset, payload does not
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			s1Valid <= 1'b0;
		else
			s1Valid <= iss.issueValid;
	end

	always_ff @(posedge clk)
	begin
		s1Bypass <= (iss.issueK == '0);
		s1R <= iss.issueR;
		// Doubling -1 by -1 overflows
		if (hiProd == 32'sh4000_0000)
			s1Prod <= maxWord32;
		else
			s1Prod <= hiProd <<< 1;
		// mult() is the product shifted right 15
		s1M1 <= crossHiLo[30:15];
		s1M2 <= crossLoHi[30:15];
	end

	//////////////////////////////////////////////////
	// Stage 2
	//////////////////////////////////////////////////

	// Two L_mac steps, each adds twice the cross term
	assign sum1 = satAdd(s1Prod, word32'(s1M1) <<< 1);
	assign sum2 = satAdd(sum1, word32'(s1M2) <<< 1);

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			res.resValid <= 1'b0;
		else
			res.resValid <= s1Valid;
	end

	// r'(0) is r(0) unchanged
	always_ff @(posedge clk)
	begin
		res.resData <= s1Bypass ? s1R : sum2;
	end

	// Same registered result to the sink
	assign outValid = res.resValid;
	assign outData = res.resData;

endmodule

`default_nettype wire

/* design/fixPkg.sv */
`default_nettype none

package fixPkg;

	//////////////////////////////////////////////////
	// Fixed-point word types
	//////////////////////////////////////////////////

	// Q15 half-word, used for hi/lo splits and the lag table
	typedef logic signed [15:0] word16;

	// Q31 word, carries r(k) and r'(k)
	typedef logic signed [31:0] word32;

	// Saturation limits of the 32-bit accumulator
	localparam word32 maxWord32 = 32'sh7FFF_FFFF;
	localparam word32 minWord32 = 32'sh8000_0000;

	//////////////////////////////////////////////////
	// Lag window for k = 1..10
	//////////////////////////////////////////////////

	// Bandwidth expansion, stored as DPF hi/lo halves
	// Entry 0 belongs to k = 1
	localparam word16 lagHiTable [10] = '{
		16'sd32728, 16'sd32619, 16'sd32438, 16'sd32187, 16'sd31867,
		16'sd31480, 16'sd31029, 16'sd30517, 16'sd29946, 16'sd29321
	};

	// Low halves are already in the shifted-by-one DPF form
	localparam word16 lagLoTable [10] = '{
		16'sd11904, 16'sd17280, 16'sd30720, 16'sd25856, 16'sd24192,
		16'sd28992, 16'sd24384, 16'sd7360,  16'sd19520, 16'sd14784
	};

endpackage

`default_nettype wire

/* design/lagWindowCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module lagWindowCtrl
	import fixPkg::*, streamPkg::*;
(
	input wire logic clk,
	input wire logic rstN,
	input wire logic bufEmpty,
	output logic pop,
	input wire word32 popData,
	input wire logic outCredit,
	mpyIf.issue iss
);

	ctrlState state;
	ctrlState nextState;

	// Sink credits not yet taken by an issued product
	creditCnt credits;

	// Position of the next word in its frame
	coefIdx k;

	// Products between issue and result
	logic [$clog2(mulLatency + 1) - 1:0] inFlight;

	// Work and credit both present
	logic canIssue;

	//////////////////////////////////////////////////
	// Issue
	//////////////////////////////////////////////////

	assign canIssue = !bufEmpty && (credits != '0);

	// Pop and issue in the same cycle
	assign pop = canIssue && (state == issue);

	assign iss.issueValid = pop;
	assign iss.issueK = k;
	assign iss.issueR = popData;

	//////////////////////////////////////////////////
	// FSM
	//////////////////////////////////////////////////

	always_comb
	begin
		nextState = state;
		case (state)
			idle:
			begin
				// Data waiting without credit parks in stall
				if (canIssue)
					nextState = issue;
				else if (!bufEmpty)
					nextState = stall;
			end
			issue:
			begin
				if (!canIssue)
					nextState = stall;
			end
			stall:
			begin
				// Back to idle once drained and nothing in flight
				if (canIssue)
					nextState = issue;
				else if (bufEmpty && inFlight == '0)
					nextState = idle;
			end
			default:
				nextState = idle;
		endcase
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			state <= idle;
		else
			state <= nextState;
	end

	//////////////////////////////////////////////////
	// Counters
	//////////////////////////////////////////////////

	// Grant and spend in one cycle cancel
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			credits <= '0;
		else if (outCredit && !pop)
			credits <= credits + 1'b1;
		else if (pop && !outCredit)
			credits <= credits - 1'b1;
	end

	// k wraps at the frame end
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			k <= '0;
		else if (pop)
		begin
			if (k == coefIdx'(frameLen - 1))
				k <= '0;
			else
				k <= k + 1'b1;
		end
	end

	// Retired by resValid
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			inFlight <= '0;
		else if (pop && !iss.resValid)
			inFlight <= inFlight + 1'b1;
		else if (iss.resValid && !pop)
			inFlight <= inFlight - 1'b1;
	end

endmodule

`default_nettype wire

/* design/lagWindowTop.sv */
`timescale 1ns/1ps
`default_nettype none

module lagWindowTop
	import fixPkg::*;
(
	input wire logic clk,
	input wire logic rstN,
	input wire logic inValid,
	input wire word32 inData,
	output logic inCredit,
	output logic outValid,
	output word32 outData,
	input wire logic outCredit
);

	// Buffer to control
	logic bufEmpty;
	logic pop;
	word32 popData;

	// Control to multiplier
	mpyIf mpyBus ();

	//////////////////////////////////////////////////
	// Input ring buffer
	//////////////////////////////////////////////////

	autocorrBuffer buffer (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.inData(inData),
		.bufEmpty(bufEmpty),
		.pop(pop),
		.popData(popData),
		.inCredit(inCredit)
	);

	// Credits and k sequencing
	lagWindowCtrl ctrl (
		.clk(clk),
		.rstN(rstN),
		.bufEmpty(bufEmpty),
		.pop(pop),
		.popData(popData),
		.outCredit(outCredit),
		.iss(mpyBus.issue)
	);

	// Mpy_32 pipeline
	dpfMultiplier multiplier (
		.clk(clk),
		.rstN(rstN),
		.res(mpyBus.result),
		.iss(mpyBus.issueIn),
		.outValid(outValid),
		.outData(outData)
	);

endmodule

`default_nettype wire

/* design/mpyIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface mpyIf
	import fixPkg::*, streamPkg::*;
	();

	// Issue side, driven by the controller
	logic issueValid;
	coefIdx issueK;
	word32 issueR;

	// Result side, driven by the multiplier
	logic resValid;
	word32 resData;

	// Controller view; resValid retires in-flight products
	modport issue (
		output issueValid, issueK, issueR,
		input resValid
	);

	// Multiplier view of its own results
	modport result (
		output resValid, resData
	);

	// Multiplier view of the issue side
	modport issueIn (
		input issueValid, issueK, issueR
	);

endinterface

`default_nettype wire

/* design/streamPkg.sv */
`default_nettype none

package streamPkg;

	//////////////////////////////////////////////////
	// Frame layout
	//////////////////////////////////////////////////

	// r(0) to r(10)
	localparam int frameLen = 11;

	// Coefficient index k
	typedef logic [3:0] coefIdx;

	//////////////////////////////////////////////////
	// Input buffer and credits
	//////////////////////////////////////////////////

	// Buffer depth, also the credits the source holds after reset
	localparam int bufDepth = 16;
	typedef logic [3:0] bufPtr;

	// Output credits granted by the sink and not yet spent
	typedef logic [4:0] creditCnt;

	// Issue to result, in cycles
	localparam int mulLatency = 2;

	// Control FSM
	typedef enum logic [1:0] {idle, issue, stall} ctrlState;

endpackage

`default_nettype wire

/* project.f */
design/fixPkg.sv
design/streamPkg.sv
design/mpyIf.sv
design/autocorrBuffer.sv
design/lagWindowCtrl.sv
design/dpfMultiplier.sv
design/lagWindowTop.sv
test/lagWindowTb.sv

/* test/lagWindowTb.sv */
`timescale 1ns/1ps
`default_nettype none

module lagWindowTb
	import fixPkg::*, streamPkg::*;
	();

	localparam int numFrames = 3;
	localparam int waitLimit = 200;

	logic clk;
	logic rstN;
	logic inValid;
	word32 inData;
	logic inCredit;
	logic outValid;
	word32 outData;
	logic outCredit;

	// Input and expected pairs, frame after frame
	word32 vectors [numFrames * frameLen * 2];

	// Expected results in send order
	word32 expQ [$];

	// Source side bookkeeping
	int sentCount;
	int returnedCount;

	// Sink side bookkeeping
	int grantedCount;
	int outCount;

	int errorCount;
	int testErrors;
	int testsRun;
	int seedVal;

	// Set by the first wait that gives up
	logic timedOut;

	// High while outputs and returned credits must stay quiet
	logic quietCheck;

	lagWindowTop DUT (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.inData(inData),
		.inCredit(inCredit),
		.outValid(outValid),
		.outData(outData),
		.outCredit(outCredit)
	);

	// 20 ns period
	always #10 clk = ~clk;

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic finishRun();
		$display("Tests run %0d, words checked %0d, errors %0d", testsRun, outCount, errorCount);
		if (errorCount == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	endtask

	task automatic reportTimeout(input string why);
		$display("%s", why);
		errorCount++;
		timedOut = 1'b1;
	endtask

	// Credits the source model holds right now
	function automatic int sourceCredits();
		return bufDepth - (sentCount - returnedCount);
	endfunction

	task automatic startTest();
		testErrors = errorCount;
	endtask

	task automatic endTest(input string name);
		testsRun++;
		$display("Test %0d %s: %0d errors", testsRun, name, errorCount - testErrors);
	endtask

	// Compare one result with the head of the queue
	task automatic checkOutput(input word32 got);
		word32 exp;
		assert (expQ.size() != 0)
		else
		begin
			$display("Output word arrived while none was expected");
			errorCount++;
		end
		if (expQ.size() != 0)
		begin
			exp = expQ.pop_front();
			assert (got === exp)
			else
			begin
				$display("Fail outData got %h expected %h", got, exp);
				errorCount++;
			end
		end
	endtask

	// Frames back to back, one word per credit held
	task automatic sendFrames(input int first, input int count);
		int w;
		int idx;
		int cycles;
		for (w = 0; w < count * frameLen && !timedOut; w++)
		begin
			@(posedge clk);
			cycles = 0;
			while (sourceCredits() <= 0 && cycles < waitLimit)
			begin
				inValid <= 1'b0;
				@(posedge clk);
				cycles++;
			end
			if (sourceCredits() <= 0)
				reportTimeout("Source waited too long for a credit");
			else
			begin
				idx = (first * frameLen + w) * 2;
				inValid <= 1'b1;
				inData <= vectors[idx];
				expQ.push_back(vectors[idx + 1]);
				sentCount++;
			end
		end
		@(posedge clk);
		inValid <= 1'b0;
	endtask

	// One pulse per credit, random idle gap after each
	task automatic grantCredits(input int count, input int maxGap);
		int c;
		int gap;
		for (c = 0; c < count; c++)
		begin
			@(posedge clk);
			outCredit <= 1'b1;
			gap = $urandom_range(maxGap, 0);
			repeat (gap)
			begin
				@(posedge clk);
				outCredit <= 1'b0;
			end
		end
		@(posedge clk);
		outCredit <= 1'b0;
	endtask

	task automatic waitForOutputs(input int target);
		int cycles;
		cycles = 0;
		while (!timedOut && outCount < target && cycles < waitLimit)
		begin
			@(posedge clk);
			cycles++;
		end
		if (!timedOut && outCount < target)
			reportTimeout("Timed out waiting for output words");
	endtask

	task automatic waitForCreditsBack();
		int cycles;
		cycles = 0;
		while (!timedOut && returnedCount < sentCount && cycles < waitLimit)
		begin
			@(posedge clk);
			cycles++;
		end
		if (!timedOut && returnedCount < sentCount)
			reportTimeout("Timed out waiting for input credits to return");
	endtask

	task automatic drain();
		waitForOutputs(sentCount);
		waitForCreditsBack();
	endtask

	//////////////////////////////////////////////////
	// Monitor
	//////////////////////////////////////////////////

	always @(posedge clk)
	begin
		if (inCredit)
			returnedCount <= returnedCount + 1;
		if (outCredit)
			grantedCount <= grantedCount + 1;
		if (outValid)
		begin
			checkOutput(outData);
			// Never more words than the sink allowed
			assert (outCount < grantedCount)
			else
			begin
				$display("More output words than credits granted");
				errorCount++;
			end
			outCount <= outCount + 1;
		end
		if (quietCheck)
		begin
			assert (!outValid)
			else
			begin
				$display("Fail outValid got %h expected 0", outValid);
				errorCount++;
			end
			assert (!inCredit)
			else
			begin
				$display("Fail inCredit got %h expected 0", inCredit);
				errorCount++;
			end
		end
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial
	begin
		int i;
		int target;
		seedVal = $urandom(32'h97961596);
		$readmemh("test/lagWindowTestdata.hex", vectors);
		clk = 1'b0;
		rstN = 1'b0;
		inValid = 1'b0;
		inData = '0;
		outCredit = 1'b0;
		quietCheck = 1'b0;
		timedOut = 1'b0;
		sentCount = 0;
		returnedCount = 0;
		grantedCount = 0;
		outCount = 0;
		errorCount = 0;
		testsRun = 0;
		repeat (8) @(posedge clk);
		rstN <= 1'b1;

		// Whole frame buffered, sink grants nothing
		startTest();
		quietCheck <= 1'b1;
		sendFrames(0, 1);
		repeat (12) @(posedge clk);
		quietCheck <= 1'b0;
		endTest("no credit, no output");

		// Buffered frame released word by word
		startTest();
		for (i = 0; i < frameLen; i++)
		begin
			target = outCount + 1;
			grantCredits(1, 0);
			waitForOutputs(target);
		end
		waitForCreditsBack();
		endTest("one credit per word");

		startTest();
		fork
			sendFrames(0, numFrames);
			grantCredits(numFrames * frameLen, 0);
		join
		drain();
		endTest("three frames back to back");

		// Sparse credits, buffer fills and source stalls
		startTest();
		fork
			sendFrames(1, 2);
			grantCredits(2 * frameLen, 6);
		join
		drain();
		endTest("random credit gaps");

		// Extra returned credits show up as a surplus here
		startTest();
		assert (sourceCredits() == bufDepth)
		else
		begin
			$display("Fail sourceCredits got %h expected %h", sourceCredits(), bufDepth);
			errorCount++;
		end
		endTest("credit conservation");

		startTest();
		fork
			sendFrames(2, 1);
			grantCredits(frameLen, 0);
		join
		drain();
		endTest("full-scale words");

		finishRun();
	end

endmodule

`default_nettype wire

/* test/lagWindowTestdata.hex */
// Columns: input word r(k), expected r'(k), both hex
// Eleven lines per frame, k = 0 to 10 in order
// Frame 0, half-scale words
12345678 12345678
40000000 3FEC2E80
40000000 3FB5C380
40000000 3F5B7800
40000000 3EDDE500
40000000 3E3DDE80
40000000 3D7C7140
40000000 3C9ADF40
40000000 3B9A9CC0
40000000 3A7D4C40
40000000 3944B9C0
// Frame 1, negative words and words with a nonzero low half
0ABCDEF0 0ABCDEF0
C0000000 C013D180
20008000 1FDB612A
C0000000 C0A48800
20008000 1F6F703A
C0000000 C1C22180
20008000 1EBEB398
C0000000 C36520C0
20008000 1DCDC594
C0000000 C582B3C0
20008000 1CA2CF68
// Frame 2, words at the saturation limits
80000000 80000000
7FFFFFFF 7FD85CFC
80000000 80947900
7FFFFFFF 7EB6EFFC
80000000 82443600
7FFFFFFF 7C7BBCFC
80000000 85071D80
7FFFFFFF 7935BE7C
80000000 88CAC680
7FFFFFFF 74FA987C
80000000 8D768C80
